// File: tb.f
+incdir+tb
verilog/lcd_bus_pkg.sv
verilog/lcd_seq_pkg.sv
verilog/lcd_phase_seq.sv
verilog/lcd_text_rom.sv
verilog/lcd_bus_driver.sv
verilog/lcd_top.sv
tb/tb_lcd_top.sv

// File: tb/lcd_tb_ref.svh
`ifndef lcd_tb_ref_svh
`define lcd_tb_ref_svh

// panel texts, first character in the top byte
localparam logic [127:0] title_line1 = "1.Start Game    ";
localparam logic [127:0] title_line2 = "2.LastGame Score";
localparam logic [127:0] music_line1 = "1.music12.music2";
localparam logic [127:0] music_line2 = "3.music3        ";
localparam logic [127:0] score_line1 = "Last Game Score ";
localparam logic [127:0] score_line2 = {16{8'h20}};

function automatic logic valid_screen(input logic [2:0] scr);
   valid_screen = (scr <= 3'd2);
endfunction

function automatic logic [7:0] text_char(input logic [2:0] scr, input logic second,
                                         input int col);
   logic [127:0] txt;
   case (scr)
      3'd0:    txt = second ? title_line2 : title_line1;
      3'd1:    txt = second ? music_line2 : music_line1;
      default: txt = second ? score_line2 : score_line1;
   endcase
   text_char = txt[8*(15-col) +: 8];
endfunction

// {rs, rw, data} expected after the edge at position pos
function automatic logic [9:0] expected_bus(input int pos, input logic [2:0] scr);
   int   q;
   int   lstep;
   logic second;
   expected_bus = {2'b00, 8'h00};
   if (pos <= 70) begin
      expected_bus = {2'b11, 8'h00};             // idle while the panel powers up
   end else if (pos <= 101) begin
      expected_bus = {2'b00, 8'h3C};
   end else if (pos <= 132) begin
      expected_bus = {2'b00, 8'h0C};
   end else if (pos <= 163) begin
      expected_bus = {2'b00, 8'h06};
   end else begin
      q = (pos - 164) % 644;
      if (q >= 443) begin
         expected_bus = {2'b00, 8'h06};          // entry refresh
      end else if (q >= 42) begin
         expected_bus = {2'b00, 8'h02};          // return home
      end else begin
         second = (q >= 21);
         lstep  = second ? q - 21 : q;
         if (lstep == 0) begin
            expected_bus = {2'b00, (second ? 8'hC0 : 8'h80)};
         end else if (lstep <= 16) begin
            expected_bus = {2'b10, text_char(scr, second, lstep - 1)};
         end else begin
            expected_bus = {2'b10, 8'h20};       // past the text
         end
      end
   end
endfunction

`endif

// File: tb/tb_lcd_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lcd_top;
   import lcd_bus_pkg::*;
   import lcd_seq_pkg::*;

   localparam time clk_period      = 100;
   localparam int  reset_cycles    = 10;
   localparam int  num_loops       = 6;
   localparam int  loop_cycles     = 644;
   localparam int  watchdog_cycles = 808 + loop_cycles*num_loops + 100;

   logic      resetn;                           // clock
   logic      clk;                              // reset, active high
   screen_t   screen;
   logic      lcd_e;
   logic      lcd_rs;
   logic      lcd_rw;
   lcd_word_t lcd_data;

   integer    seed;
   int        stim_k;                           // edge index seen by stimulus
   int        pos;                              // edge index seen by compare
   int        last_start;
   int        starts;
   logic      prev_start;
   logic      exp_rs;
   logic      exp_rw;
   lcd_word_t exp_data;

   `include "lcd_tb_ref.svh"

   lcd_top UUT (
      .resetn   (resetn),
      .clk      (clk),
      .screen   (screen),
      .lcd_e    (lcd_e),
      .lcd_rs   (lcd_rs),
      .lcd_rw   (lcd_rw),
      .lcd_data (lcd_data)
   );

   always #(clk_period/2) resetn = ~resetn;

   task automatic check_ctrl(input string name, input logic [1:0] exp, input logic [1:0] act);
      if (act !== exp) begin
         $display("Error in %s: expected rs/rw %b, actual %b", name, exp, act);
         $display("TEST RESULT: FAIL");
         $fatal(1, "control pair mismatch");
      end
   endtask

   task automatic compare_word(input string name, input lcd_word_t exp, input lcd_word_t act);
      if (act !== exp) begin
         $display("Error in %s: expected data %02h, actual %02h", name, exp, act);
         $display("TEST RESULT: FAIL");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic verify_enable(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Error in %s: expected lcd_e %b, actual %b", name, exp, act);
         $display("TEST RESULT: FAIL");
         $fatal(1, "enable mismatch");
      end
   endtask

   task automatic loop_period_check(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("Error in %s: expected %0d cycles, actual %0d", name, exp, act);
         $display("TEST RESULT: FAIL");
         $fatal(1, "loop period mismatch");
      end
   endtask

   task automatic advance_to(input int k);
      while (stim_k < k) begin
         @(posedge resetn);
         stim_k++;
      end
   endtask

   function automatic int loop_start(input int n);
      loop_start = 164 + loop_cycles*n;
   endfunction

   function automatic string phase_label(input int p);
      int q;
      q = (p - 164) % loop_cycles;
      if (p <= 70)        phase_label = "power_wait";
      else if (p <= 101)  phase_label = "function_set";
      else if (p <= 132)  phase_label = "display_on";
      else if (p <= 163)  phase_label = "entry_mode";
      else if (q <= 20)   phase_label = "line1";
      else if (q <= 41)   phase_label = "line2";
      else if (q <= 442)  phase_label = "home_wait";
      else                phase_label = "entry_refresh";
   endfunction

   always @(posedge resetn) begin : compare_bus
      screen_t    scr_now;
      logic       rst_now;
      logic [9:0] exp_bus;
      string      name;
      scr_now = screen;                         // value the DUT samples at this edge
      rst_now = clk;
      #1;
      verify_enable("enable_rise", 1'b1, lcd_e);
      if (rst_now) begin
         exp_rs   = 1'b1;
         exp_rw   = 1'b1;
         exp_data = '0;
         name     = "reset";
      end else begin
         if (valid_screen(scr_now)) begin     // otherwise the bus holds
            exp_bus            = expected_bus(pos, scr_now);
            exp_rs             = exp_bus[9];
            exp_rw             = exp_bus[8];
            exp_data.char_code = exp_bus[7:0];
         end
         name = $sformatf("%s pos %0d screen %0d", phase_label(pos), pos, scr_now);
      end
      check_ctrl(name, {exp_rs, exp_rw}, {lcd_rs, lcd_rw});
      compare_word(name, exp_data, lcd_data);
      if (!rst_now) begin
         if (!lcd_rs && lcd_data.char_code == 8'h80 && !prev_start) begin
            if (last_start >= 0) begin
               loop_period_check("loop_period", loop_cycles, pos - last_start);
            end
            last_start = pos;
            starts++;
         end
         prev_start = !lcd_rs && (lcd_data.char_code == 8'h80);
         pos++;
      end
   end

   always @(negedge resetn) begin
      #1;
      verify_enable("enable_fall", 1'b0, lcd_e);
   end

   initial begin : watchdog
      #(clk_period * watchdog_cycles);
      $display("watchdog expired before the run reached its end");
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
   end

   initial begin : stimulus
      logic [31:0] rnd;
      int          k;
      seed       = 32'h70fd_b540;
      resetn     = 1'b0;
      clk        = 1'b1;
      screen     = screen_title;
      stim_k     = -1;
      pos        = 0;
      last_start = -1;
      starts     = 0;
      prev_start = 1'b0;
      exp_rs     = 1'b1;
      exp_rw     = 1'b1;
      exp_data   = '0;

      repeat (reset_cycles) @(posedge resetn);
      clk <= 1'b0;
      stim_k = -1;

      advance_to(loop_start(1) - 1);
      screen <= screen_music;
      advance_to(loop_start(2) - 1);
      screen <= screen_score;
      advance_to(loop_start(3) - 1);
      screen <= screen_title;
      advance_to(loop_start(3) + 5);
      screen <= 3'd5;                           // freeze inside line1
      advance_to(loop_start(3) + 24);
      screen <= screen_music;
      advance_to(loop_start(3) + 440);
      screen <= 3'd7;                           // freeze across home to refresh
      advance_to(loop_start(3) + 450);
      screen <= screen_score;

      advance_to(loop_start(4) - 1);
      screen <= screen_title;
      for (k = loop_start(4) + 1; k < loop_start(5) - 1; k = k + 4) begin
         advance_to(k);
         rnd = $random(seed);
         screen <= rnd[2:0];
      end
      advance_to(loop_start(5) - 1);
      screen <= screen_title;

      advance_to(loop_start(num_loops) - 1);
      @(negedge resetn);
      if (starts == num_loops) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         $display("only %0d of %0d loop starts were seen on the bus", starts, num_loops);
         $display("TEST RESULT: FAIL");
         $fatal(1, "missing loop starts");
      end
   end

endmodule

`default_nettype wire

// File: verilog/lcd_top.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_top (
   input  logic                   resetn,
   input  logic                   clk,
   input  lcd_seq_pkg::screen_t   screen,
   output logic                   lcd_e,
   output logic                   lcd_rs,
   output logic                   lcd_rw,
   output lcd_bus_pkg::lcd_word_t lcd_data
);
   import lcd_bus_pkg::*;
   import lcd_seq_pkg::*;

   phase_t    phase;
   step_t     step;
   lcd_word_t ch;

   assign lcd_e = resetn;                       // enable strobe follows the clock

   lcd_phase_seq u_seq (
      .resetn (resetn),
      .clk    (clk),
      .phase  (phase),
      .step   (step)
   );

   lcd_text_rom u_rom (
      .screen (screen),
      .phase  (phase),
      .step   (step),
      .ch     (ch)
   );

   lcd_bus_driver u_drv (
      .resetn   (resetn),
      .clk      (clk),
      .screen   (screen),
      .phase    (phase),
      .step     (step),
      .ch       (ch),
      .lcd_rs   (lcd_rs),
      .lcd_rw   (lcd_rw),
      .lcd_data (lcd_data)
   );

endmodule

`default_nettype wire

// File: verilog/lcd_bus_driver.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_driver (
   input  logic                   resetn,
   input  logic                   clk,
   input  lcd_seq_pkg::screen_t   screen,
   input  lcd_seq_pkg::phase_t    phase,
   input  lcd_seq_pkg::step_t     step,
   input  lcd_bus_pkg::lcd_word_t ch,
   output logic                   lcd_rs,
   output logic                   lcd_rw,
   output lcd_bus_pkg::lcd_word_t lcd_data
);
   import lcd_bus_pkg::*;
   import lcd_seq_pkg::*;

   logic      screen_ok;
   logic      rs_nxt;
   logic      rw_nxt;
   lcd_word_t word_nxt;

   assign screen_ok = screen inside {screen_title, screen_music, screen_score};

   always_comb begin
      rs_nxt   = 1'b0;
      rw_nxt   = 1'b0;
      word_nxt = '0;
      case (phase)
         power_wait: begin
            rs_nxt = 1'b1;                      // idle levels
            rw_nxt = 1'b1;
         end
         function_set:  word_nxt = lcd_word_t'(cmd_function_set);
         display_on:    word_nxt = lcd_word_t'(cmd_display_on);
         entry_mode:    word_nxt = lcd_word_t'(cmd_entry_mode);
         line1, line2: begin
            if (step == '0) begin
               word_nxt.cmd.set_addr = 1'b1;
               word_nxt.cmd.addr     = (phase == line2) ? addr_line2 : addr_line1;
            end else begin
               rs_nxt             = 1'b1;       // character write
               word_nxt.char_code = ch.char_code;
            end
         end
         home_wait:     word_nxt = lcd_word_t'(cmd_return_home);
         entry_refresh: word_nxt = lcd_word_t'(cmd_entry_mode);
         default:       word_nxt = '0;
      endcase
   end

   always_ff @(posedge resetn or posedge clk) begin
      if (clk) begin
         lcd_rs   <= 1'b1;
         lcd_rw   <= 1'b1;
         lcd_data <= '0;
      end else if (screen_ok) begin             // invalid screen freezes the bus
         lcd_rs   <= rs_nxt;
         lcd_rw   <= rw_nxt;
         lcd_data <= word_nxt;
      end
   end

   // in a line phase, a command write is only ever a set-address
   a_line_cmd_is_addr : assert property (
      @(posedge resetn) disable iff (clk)
      (screen_ok && phase inside {line1, line2}) |=> (lcd_rs || lcd_data.cmd.set_addr)
   );

endmodule

`default_nettype wire

// File: verilog/lcd_text_rom.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_text_rom (
   input  lcd_seq_pkg::screen_t   screen,
   input  lcd_seq_pkg::phase_t    phase,
   input  lcd_seq_pkg::step_t     step,
   output lcd_bus_pkg::lcd_word_t ch
);
   import lcd_bus_pkg::*;
   import lcd_seq_pkg::*;

   step_t                                 col;
   logic                                  second_line;
   logic                                  in_text;
   logic [lcd_data_width*line_chars-1:0]  text;

   assign col         = step - step_t'(1);     // step 0 carries the address
   assign second_line = (phase == line2);
   assign in_text     = (phase inside {line1, line2}) && (col < step_t'(line_chars));

   always_comb begin
      text = {line_chars{char_space}};          // unknown screens stay blank
      case (screen)
         screen_title: begin
            if (second_line) begin
               text = "2.LastGame Score";
            end else begin
               text = "1.Start Game    ";
            end
         end
         screen_music: begin
            if (second_line) begin
               text = "3.music3        ";
            end else begin
               text = "1.music12.music2";
            end
         end
         screen_score: begin
            if (second_line) begin
               text = {line_chars{char_space}};
            end else begin
               text = "Last Game Score ";
            end
         end
         default: begin
            text = {line_chars{char_space}};
         end
      endcase
   end

   // leftmost character sits in the top byte
   always_comb begin
      ch.char_code = char_space;
      if (in_text) begin
         ch.char_code = text[lcd_data_width*(line_chars-1-col[3:0]) +: lcd_data_width];
      end
   end

endmodule

`default_nettype wire

// File: verilog/lcd_phase_seq.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_phase_seq (
   input  logic                resetn,
   input  logic                clk,
   output lcd_seq_pkg::phase_t phase,
   output lcd_seq_pkg::step_t  step
);
   import lcd_seq_pkg::*;

   phase_t phase_nxt;
   logic   phase_done;

   assign phase_done = (step == phase_last(phase));

   always_comb begin
      case (phase)
         power_wait:    phase_nxt = function_set;
         function_set:  phase_nxt = display_on;
         display_on:    phase_nxt = entry_mode;
         entry_mode:    phase_nxt = line1;
         line1:         phase_nxt = line2;
         line2:         phase_nxt = home_wait;
         home_wait:     phase_nxt = entry_refresh;
         entry_refresh: phase_nxt = line1;      // loop back, no new set-up
         default:       phase_nxt = power_wait;
      endcase
   end

   always_ff @(posedge resetn or posedge clk) begin
      if (clk) begin
         phase <= power_wait;
         step  <= '0;
      end else if (phase_done) begin
         phase <= phase_nxt;
         step  <= '0;
      end else begin
         step  <= step + step_t'(1);
      end
   end

   // step stays inside the current phase window
   a_step_in_range : assert property (
      @(posedge resetn) disable iff (clk)
      step <= phase_last(phase)
   );

endmodule

`default_nettype wire

// File: verilog/lcd_seq_pkg.sv
`default_nettype none

package lcd_seq_pkg;

   typedef enum logic [2:0] {
      power_wait,
      function_set,
      display_on,
      entry_mode,
      line1,
      line2,
      home_wait,
      entry_refresh
   } phase_t;

   typedef logic [8:0] step_t;            // counts up to 400

   // last step of each phase
   localparam step_t phase_len_power_wait = 9'd70;
   localparam step_t phase_len_command    = 9'd30;
   localparam step_t phase_len_line       = 9'd20;
   localparam step_t phase_len_home       = 9'd400;
   localparam step_t phase_len_refresh    = 9'd200;

   localparam int line_chars = 16;

   typedef logic [2:0] screen_t;

   localparam screen_t screen_title = 3'd0;
   localparam screen_t screen_music = 3'd1;
   localparam screen_t screen_score = 3'd2;

   function automatic step_t phase_last(input phase_t p);
      case (p)
         power_wait:                           phase_last = phase_len_power_wait;
         function_set, display_on, entry_mode: phase_last = phase_len_command;
         line1, line2:                         phase_last = phase_len_line;
         home_wait:                            phase_last = phase_len_home;
         default:                              phase_last = phase_len_refresh;
      endcase
   endfunction

endpackage

`default_nettype wire

// File: verilog/lcd_bus_pkg.sv
`default_nettype none

package lcd_bus_pkg;

   localparam int lcd_data_width = 8;
   localparam int lcd_addr_width = lcd_data_width - 1;   // ddram address field

   // one bus byte, read either as a command or as a character
   typedef union packed {
      logic [lcd_data_width-1:0] char_code;
      struct packed {
         logic                      set_addr;            // 1 = set ddram address
         logic [lcd_addr_width-1:0] addr;
      } cmd;
   } lcd_word_t;

   // instruction codes
   localparam logic [lcd_data_width-1:0] cmd_function_set = 8'h3C;   // 8 bit, 2 lines
   localparam logic [lcd_data_width-1:0] cmd_display_on   = 8'h0C;   // no cursor
   localparam logic [lcd_data_width-1:0] cmd_entry_mode   = 8'h06;   // increment, no shift
   localparam logic [lcd_data_width-1:0] cmd_return_home  = 8'h02;

   // line start addresses
   localparam logic [lcd_addr_width-1:0] addr_line1 = 7'h00;
   localparam logic [lcd_addr_width-1:0] addr_line2 = 7'h40;

   localparam logic [lcd_data_width-1:0] char_space = 8'h20;

endpackage

`default_nettype wire
